// ==== dmm_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// dmm measurement-cycle controller shared definitions
// widths, register map, mode codes and precharge switch levels
////////////////////////////////////////////////////////////////////////////

package dmm_pkg;

  // widths with a meaning
  localparam int AZMUX_WIDTH         = 4;
  localparam int DEFAULT_COUNT_WIDTH = 24;
  localparam int MEAS_COUNT_WIDTH    = 16;
  localparam int APB_ADDR_WIDTH      = 8;
  localparam int APB_DATA_WIDTH      = 32;

  // mux code, bit 3 enable, bits 2:0 channel
  typedef logic [AZMUX_WIDTH-1:0]         azmux_t;
  // clk cycles for the precharge and boot pauses
  typedef logic [DEFAULT_COUNT_WIDTH-1:0] count_t;
  // finished conversions, wraps
  typedef logic [MEAS_COUNT_WIDTH-1:0]    meas_count_t;
  typedef logic [APB_ADDR_WIDTH-1:0]      apb_addr_t;
  typedef logic [APB_DATA_WIDTH-1:0]      apb_data_t;

  // code 3 is not a mode, it is stored as direct
  typedef enum logic [1:0] {
    MODE_DIRECT = 2'd0,
    MODE_NO_AZ  = 2'd1,
    MODE_AZ     = 2'd2
  } mode_t;

  // precharge switch levels
  localparam logic SW_PC_SIGNAL = 1'b1;
  localparam logic SW_PC_BOOT   = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // register map, byte addresses
  localparam apb_addr_t ADDR_CTRL      = 8'h00;
  localparam apb_addr_t ADDR_PRECHARGE = 8'h04;
  localparam apb_addr_t ADDR_AZMUX     = 8'h08;
  localparam apb_addr_t ADDR_STATUS    = 8'h0C;

  localparam count_t PRECHARGE_RESET = 24'd1000;
  localparam azmux_t AZMUX_LO_RESET  = 4'h8;
  localparam azmux_t AZMUX_HI_RESET  = 4'h9;

endpackage

// ==== modulation_no_az.sv ====
////////////////////////////////////////////////////////////////////////////
// no-az sequencer
// precharge pause then one adc conversion, pc on signal, mux on hi
////////////////////////////////////////////////////////////////////////////

module modulation_no_az #(
  parameter int COUNT_WIDTH = 24
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  dmm_pkg::count_t precharge_n,
  input  dmm_pkg::azmux_t azmux_hi,
  input  logic            adc_measure_done,
  output logic            sw_pc_ctl,
  output dmm_pkg::azmux_t azmux,
  output logic            adc_measure_start,
  output logic [1:0]      monitor
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_PC_LOAD,
    S_PC_WAIT,
    S_START,
    S_WAIT_DONE
  } state_t;

  state_t                 state_q;
  state_t                 state_d;
  logic [COUNT_WIDTH-1:0] count_q;

  // next state, enable low forces idle and drops a pending start
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    state_d = S_PC_LOAD;
      S_PC_LOAD: state_d = S_PC_WAIT;
      // the load cycle is part of the pause, so leave one count early
      S_PC_WAIT:
        if (count_q <= COUNT_WIDTH'(1))
          state_d = S_START;
      S_START:   state_d = S_WAIT_DONE;
      // hold here for as long as the adc takes
      S_WAIT_DONE:
        if (adc_measure_done)
          state_d = S_PC_LOAD;
      default:   state_d = S_IDLE;
    endcase
    if (!enable)
      state_d = S_IDLE;
  end

  // outputs registered from the next state
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q           <= S_IDLE;
      count_q           <= '0;
      sw_pc_ctl         <= dmm_pkg::SW_PC_BOOT;
      azmux             <= dmm_pkg::AZMUX_HI_RESET;
      adc_measure_start <= 1'b0;
      monitor           <= 2'b00;
    end
    else
    begin
      state_q <= state_d;
      // precharge down-counter
      if (state_q == S_PC_LOAD)
        count_q <= COUNT_WIDTH'(precharge_n);
      else if (state_q == S_PC_WAIT)
        count_q <= count_q - COUNT_WIDTH'(1);
      sw_pc_ctl         <= (state_d == S_IDLE) ? dmm_pkg::SW_PC_BOOT : dmm_pkg::SW_PC_SIGNAL;
      azmux             <= azmux_hi;
      adc_measure_start <= (state_d == S_START);
      // bit 0 precharge, bit 1 conversion
      monitor[0]        <= (state_d == S_PC_LOAD) || (state_d == S_PC_WAIT);
      monitor[1]        <= (state_d == S_START) || (state_d == S_WAIT_DONE);
    end
  end

  // start is a single-cycle pulse
  a_start_pulse: assert property (@(posedge clk) disable iff (reset)
    adc_measure_start |=> !adc_measure_start);

  // a start is only launched from a cycle with the mode selected
  a_start_enabled: assert property (@(posedge clk) disable iff (reset)
    adc_measure_start |-> $past(enable));

endmodule

// ==== modulation_az.sv ====
////////////////////////////////////////////////////////////////////////////
// az sequencer
// precharge, hi conversion on signal, boot pause, lo conversion on lo pin
////////////////////////////////////////////////////////////////////////////

module modulation_az #(
  parameter int COUNT_WIDTH = 24
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  dmm_pkg::count_t precharge_n,
  input  dmm_pkg::azmux_t azmux_hi,
  input  dmm_pkg::azmux_t azmux_lo,
  input  logic            adc_measure_done,
  output logic            sw_pc_ctl,
  output dmm_pkg::azmux_t azmux,
  output logic            adc_measure_start,
  output logic [1:0]      monitor
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_PC_LOAD,
    S_PC_WAIT,
    S_HI_START,
    S_HI_WAIT,
    S_BOOT_LOAD,
    S_BOOT_WAIT,
    S_LO_START,
    S_LO_WAIT
  } state_t;

  state_t                 state_q;
  state_t                 state_d;
  logic [COUNT_WIDTH-1:0] count_q;
  logic                   pause_over;

  // load cycle counts as the first cycle of a pause
  assign pause_over = (count_q <= COUNT_WIDTH'(1));

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:      state_d = S_PC_LOAD;
      // precharge, pc protects the signal while the mux settles on hi
      S_PC_LOAD:   state_d = S_PC_WAIT;
      S_PC_WAIT:
        if (pause_over)
          state_d = S_HI_START;
      S_HI_START:  state_d = S_HI_WAIT;
      S_HI_WAIT:
        if (adc_measure_done)
          state_d = S_BOOT_LOAD;
      // pc back to boot before the mux moves
      S_BOOT_LOAD: state_d = S_BOOT_WAIT;
      S_BOOT_WAIT:
        if (pause_over)
          state_d = S_LO_START;
      S_LO_START:  state_d = S_LO_WAIT;
      S_LO_WAIT:
        if (adc_measure_done)
          state_d = S_PC_LOAD;
      default:     state_d = S_IDLE;
    endcase
    if (!enable)
      state_d = S_IDLE;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q           <= S_IDLE;
      count_q           <= '0;
      sw_pc_ctl         <= dmm_pkg::SW_PC_BOOT;
      azmux             <= dmm_pkg::AZMUX_HI_RESET;
      adc_measure_start <= 1'b0;
      monitor           <= 2'b00;
    end
    else
    begin
      state_q <= state_d;
      // one down-counter shared by both pauses
      if ((state_q == S_PC_LOAD) || (state_q == S_BOOT_LOAD))
        count_q <= COUNT_WIDTH'(precharge_n);
      else if ((state_q == S_PC_WAIT) || (state_q == S_BOOT_WAIT))
        count_q <= count_q - COUNT_WIDTH'(1);
      // pc on signal only for the hi conversion
      if ((state_d == S_HI_START) || (state_d == S_HI_WAIT))
        sw_pc_ctl <= dmm_pkg::SW_PC_SIGNAL;
      else
        sw_pc_ctl <= dmm_pkg::SW_PC_BOOT;
      // mux on lo only for the lo conversion
      if ((state_d == S_LO_START) || (state_d == S_LO_WAIT))
        azmux <= azmux_lo;
      else
        azmux <= azmux_hi;
      adc_measure_start <= (state_d == S_HI_START) || (state_d == S_LO_START);
      // bit 0 any pause, bit 1 any conversion
      monitor[0] <= (state_d == S_PC_LOAD) || (state_d == S_PC_WAIT)
                 || (state_d == S_BOOT_LOAD) || (state_d == S_BOOT_WAIT);
      monitor[1] <= (state_d == S_HI_START) || (state_d == S_HI_WAIT)
                 || (state_d == S_LO_START) || (state_d == S_LO_WAIT);
    end
  end

  // the hi conversion always sees the signal through the pc switch
  a_hi_on_signal: assert property (@(posedge clk) disable iff (reset)
    (adc_measure_start && (azmux == azmux_hi)) |-> (sw_pc_ctl == dmm_pkg::SW_PC_SIGNAL));

endmodule

// ==== modulation_apb_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// apb register block, zero wait states
// mode, precharge duration, mux codes and the conversion count
////////////////////////////////////////////////////////////////////////////

module modulation_apb_regs #(
  parameter int COUNT_WIDTH = 24
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  dmm_pkg::apb_addr_t   paddr,
  input  dmm_pkg::apb_data_t   pwdata,
  input  dmm_pkg::meas_count_t meas_count,
  output dmm_pkg::apb_data_t   prdata,
  output logic                 pslverr,
  output dmm_pkg::mode_t       mode,
  output dmm_pkg::count_t      precharge_n,
  output dmm_pkg::azmux_t      azmux_lo,
  output dmm_pkg::azmux_t      azmux_hi
);

  logic [COUNT_WIDTH-1:0] precharge_q;
  logic                   access;
  logic                   addr_mapped;
  logic                   addr_read_only;
  logic                   wr_en;

  // access phase of a transfer
  assign access = psel && penable;
  assign wr_en  = access && pwrite && addr_mapped && !addr_read_only;

  // address decode and read mux, valid in the access cycle
  always_comb
  begin
    addr_mapped    = 1'b1;
    addr_read_only = 1'b0;
    prdata         = '0;
    case (paddr)
      dmm_pkg::ADDR_CTRL:      prdata = dmm_pkg::apb_data_t'(mode);
      dmm_pkg::ADDR_PRECHARGE: prdata = dmm_pkg::apb_data_t'(precharge_q);
      dmm_pkg::ADDR_AZMUX:     prdata = dmm_pkg::apb_data_t'({azmux_hi, azmux_lo});
      dmm_pkg::ADDR_STATUS:
      begin
        prdata         = dmm_pkg::apb_data_t'(meas_count);
        addr_read_only = 1'b1;
      end
      default:                 addr_mapped = 1'b0;
    endcase
  end

  // unmapped address, or a write to status
  assign pslverr = access && (!addr_mapped || (pwrite && addr_read_only));

  ////////////////////////////////////////////////////////////////////////////
  // writable registers, updated at the edge that ends the access cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mode        <= dmm_pkg::MODE_DIRECT;
      precharge_q <= COUNT_WIDTH'(dmm_pkg::PRECHARGE_RESET);
      azmux_lo    <= dmm_pkg::AZMUX_LO_RESET;
      azmux_hi    <= dmm_pkg::AZMUX_HI_RESET;
    end
    else if (wr_en)
    begin
      case (paddr)
        dmm_pkg::ADDR_CTRL:
          // code 3 has no mode behind it, park instead
          if (pwdata[1:0] == 2'd3)
            mode <= dmm_pkg::MODE_DIRECT;
          else
            mode <= dmm_pkg::mode_t'(pwdata[1:0]);
        dmm_pkg::ADDR_PRECHARGE: precharge_q <= pwdata[COUNT_WIDTH-1:0];
        dmm_pkg::ADDR_AZMUX:
        begin
          azmux_lo <= pwdata[3:0];
          azmux_hi <= pwdata[7:4];
        end
        default: ;
      endcase
    end
  end

  assign precharge_n = dmm_pkg::count_t'(precharge_q);

  // apb protocol, no access phase without select
  a_penable_psel: assert property (@(posedge clk) disable iff (reset)
    penable |-> psel);

endmodule

// ==== modulation_select.sv ====
////////////////////////////////////////////////////////////////////////////
// output selector, picks the active sequencer and parks in direct mode
// also counts finished conversions and toggles the activity led
////////////////////////////////////////////////////////////////////////////

module modulation_select (
  input  logic                 clk,
  input  logic                 reset,
  input  dmm_pkg::mode_t       mode,
  input  dmm_pkg::azmux_t      azmux_lo,
  input  logic                 adc_measure_done,
  input  logic                 na_sw_pc,
  input  dmm_pkg::azmux_t      na_azmux,
  input  logic                 na_start,
  input  logic [1:0]           na_monitor,
  input  logic                 az_sw_pc,
  input  dmm_pkg::azmux_t      az_azmux,
  input  logic                 az_start,
  input  logic [1:0]           az_monitor,
  output logic                 sw_pc_ctl,
  output dmm_pkg::azmux_t      azmux,
  output logic                 adc_measure_start,
  output logic [1:0]           monitor,
  output logic                 led0,
  output dmm_pkg::meas_count_t meas_count
);

  // mode mux, direct parks pc on boot and the mux on the lo code
  always_comb
  begin
    case (mode)
      dmm_pkg::MODE_NO_AZ:
      begin
        sw_pc_ctl         = na_sw_pc;
        azmux             = na_azmux;
        adc_measure_start = na_start;
        monitor           = na_monitor;
      end
      dmm_pkg::MODE_AZ:
      begin
        sw_pc_ctl         = az_sw_pc;
        azmux             = az_azmux;
        adc_measure_start = az_start;
        monitor           = az_monitor;
      end
      default:
      begin
        sw_pc_ctl         = dmm_pkg::SW_PC_BOOT;
        azmux             = azmux_lo;
        adc_measure_start = 1'b0;
        monitor           = 2'b00;
      end
    endcase
  end

  // conversion counter, a late done after a mode change still counts
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      meas_count <= '0;
      led0       <= 1'b0;
    end
    else if (adc_measure_done && (mode != dmm_pkg::MODE_DIRECT))
    begin
      meas_count <= meas_count + 1'b1;
      led0       <= !led0;
    end
  end

endmodule

// ==== modulation_top.sv ====
////////////////////////////////////////////////////////////////////////////
// dmm measurement-cycle controller top level
// apb registers, no-az and az sequencers and the output selector
////////////////////////////////////////////////////////////////////////////

module modulation_top #(
  // width of the pause down-counters
  parameter int COUNT_WIDTH = 24
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  dmm_pkg::apb_addr_t paddr,
  input  dmm_pkg::apb_data_t pwdata,
  output dmm_pkg::apb_data_t prdata,
  output logic               pslverr,
  input  logic               adc_measure_done,
  output logic               sw_pc_ctl,
  output dmm_pkg::azmux_t    azmux,
  output logic               adc_measure_start,
  output logic [1:0]         monitor,
  output logic               led0
);

  dmm_pkg::mode_t       mode;
  dmm_pkg::count_t      precharge_n;
  dmm_pkg::azmux_t      azmux_lo;
  dmm_pkg::azmux_t      azmux_hi;
  dmm_pkg::meas_count_t meas_count;
  logic                 na_enable;
  logic                 az_enable;
  // per-sequencer outputs into the selector
  logic                 na_sw_pc;
  dmm_pkg::azmux_t      na_azmux;
  logic                 na_start;
  logic [1:0]           na_monitor;
  logic                 az_sw_pc;
  dmm_pkg::azmux_t      az_azmux;
  logic                 az_start;
  logic [1:0]           az_monitor;

  // each sequencer runs only in its own mode
  assign na_enable = (mode == dmm_pkg::MODE_NO_AZ);
  assign az_enable = (mode == dmm_pkg::MODE_AZ);

  modulation_apb_regs #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_regs (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .meas_count  (meas_count),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .mode        (mode),
    .precharge_n (precharge_n),
    .azmux_lo    (azmux_lo),
    .azmux_hi    (azmux_hi)
  );

  modulation_no_az #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_no_az (
    .clk               (clk),
    .reset             (reset),
    .enable            (na_enable),
    .precharge_n       (precharge_n),
    .azmux_hi          (azmux_hi),
    .adc_measure_done  (adc_measure_done),
    .sw_pc_ctl         (na_sw_pc),
    .azmux             (na_azmux),
    .adc_measure_start (na_start),
    .monitor           (na_monitor)
  );

  modulation_az #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_az (
    .clk               (clk),
    .reset             (reset),
    .enable            (az_enable),
    .precharge_n       (precharge_n),
    .azmux_hi          (azmux_hi),
    .azmux_lo          (azmux_lo),
    .adc_measure_done  (adc_measure_done),
    .sw_pc_ctl         (az_sw_pc),
    .azmux             (az_azmux),
    .adc_measure_start (az_start),
    .monitor           (az_monitor)
  );

  modulation_select u_select (
    .clk               (clk),
    .reset             (reset),
    .mode              (mode),
    .azmux_lo          (azmux_lo),
    .adc_measure_done  (adc_measure_done),
    .na_sw_pc          (na_sw_pc),
    .na_azmux          (na_azmux),
    .na_start          (na_start),
    .na_monitor        (na_monitor),
    .az_sw_pc          (az_sw_pc),
    .az_azmux          (az_azmux),
    .az_start          (az_start),
    .az_monitor        (az_monitor),
    .sw_pc_ctl         (sw_pc_ctl),
    .azmux             (azmux),
    .adc_measure_start (adc_measure_start),
    .monitor           (monitor),
    .led0              (led0),
    .meas_count        (meas_count)
  );

endmodule

// ==== tb_modulation.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the dmm measurement-cycle controller
// apb register access, adc model, direct, no-az and az cycles
////////////////////////////////////////////////////////////////////////////

module tb_modulation;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PRECHARGE_TEST = 10;
  // all tests need under 1000 cycles at this precharge, even with the slowest adc
  localparam int TIMEOUT_CYCLES = 4000;

  logic                 clk;
  logic                 reset;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  dmm_pkg::apb_addr_t   paddr;
  dmm_pkg::apb_data_t   pwdata;
  dmm_pkg::apb_data_t   prdata;
  logic                 pslverr;
  logic                 adc_measure_done;
  logic                 sw_pc_ctl;
  dmm_pkg::azmux_t      azmux;
  logic                 adc_measure_start;
  logic [1:0]           monitor;
  logic                 led0;

  string test_name;
  int    errors;
  int    checks;
  int    cycle;
  int    done_seen;
  int    start_seen;
  int    last_done_cycle;
  int    exp_status;
  bit    done_since_start;
  // one entry per start, and one gap per start that follows a done
  logic            start_pc[$];
  dmm_pkg::azmux_t start_mux[$];
  logic [1:0]      start_mon[$];
  int              gap_q[$];

  modulation_top #(
    .COUNT_WIDTH (24)
  ) u_dut (
    .clk               (clk),
    .reset             (reset),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .prdata            (prdata),
    .pslverr           (pslverr),
    .adc_measure_done  (adc_measure_done),
    .sw_pc_ctl         (sw_pc_ctl),
    .azmux             (azmux),
    .adc_measure_start (adc_measure_start),
    .monitor           (monitor),
    .led0              (led0)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // adc model, one done pulse 3 to 20 cycles after each start
  initial
  begin
    int delay;
    void'($urandom(25));
    forever
    begin
      @(posedge clk);
      if (adc_measure_start)
      begin
        delay = 3 + int'($urandom % 18);
        repeat (delay - 1) @(posedge clk);
        @(negedge clk);
        adc_measure_done = 1'b1;
        @(negedge clk);
        adc_measure_done = 1'b0;
      end
    end
  end

  // logs each start with the switch state, and the gap since the last done
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (!reset)
    begin
      if (adc_measure_start)
      begin
        start_seen = start_seen + 1;
        start_pc.push_back(sw_pc_ctl);
        start_mux.push_back(azmux);
        start_mon.push_back(monitor);
        if (done_since_start)
          gap_q.push_back(cycle - last_done_cycle);
        done_since_start = 1'b0;
      end
      if (adc_measure_done)
      begin
        done_seen        = done_seen + 1;
        last_done_cycle  = cycle;
        done_since_start = 1'b1;
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_data(input string what, input dmm_pkg::apb_data_t exp,
                            input dmm_pkg::apb_data_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    end
  endtask

  task automatic check_azmux(input string what, input dmm_pkg::azmux_t exp,
                             input dmm_pkg::azmux_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s %s: expected 0x%01h, actual 0x%01h", test_name, what, exp, act);
    end
  endtask

  task automatic check_pc(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s %s: expected pc %b, actual pc %b", test_name, what, exp, act);
    end
  endtask

  // bit 0 precharge, bit 1 conversion
  task automatic check_monitor(input string what, input logic [1:0] exp,
                               input logic [1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s %s: expected monitor %b, actual monitor %b", test_name, what,
               exp, act);
    end
  endtask

  // single-bit results other than the pc switch
  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input dmm_pkg::meas_count_t exp,
                             input dmm_pkg::meas_count_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_gap(input string what, input dmm_pkg::count_t exp,
                           input dmm_pkg::count_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s %s: expected %0d cycles, actual %0d", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // apb master, setup then access, no wait states
  task automatic apb_write(input dmm_pkg::apb_addr_t addr, input dmm_pkg::apb_data_t data,
                           output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    // pslverr as seen by the edge that ends the access cycle
    @(posedge clk);
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input dmm_pkg::apb_addr_t addr, output dmm_pkg::apb_data_t data,
                          output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic clear_log();
    start_pc.delete();
    start_mux.delete();
    start_mon.delete();
    gap_q.delete();
    done_since_start = 1'b0;
  endtask

  task automatic wait_dones(input int target);
    while (done_seen < target)
      @(negedge clk);
  endtask

  task automatic read_status_check();
    dmm_pkg::apb_data_t data;
    logic               err;
    apb_read(dmm_pkg::ADDR_STATUS, data, err);
    check_count("status", dmm_pkg::meas_count_t'(exp_status), data[15:0]);
    check_flag("status pslverr", 1'b0, err);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  task automatic test_reset_regs();
    dmm_pkg::apb_data_t data;
    logic               err;
    test_name = "reset_regs";
    check_flag("start", 1'b0, adc_measure_start);
    check_pc("sw_pc", dmm_pkg::SW_PC_BOOT, sw_pc_ctl);
    check_azmux("azmux", 4'h8, azmux);
    check_monitor("monitor", 2'b00, monitor);
    check_flag("led0", 1'b0, led0);
    apb_read(dmm_pkg::ADDR_CTRL, data, err);
    check_data("ctrl reset", 32'd0, data);
    check_flag("ctrl pslverr", 1'b0, err);
    apb_read(dmm_pkg::ADDR_PRECHARGE, data, err);
    check_data("precharge reset", 32'd1000, data);
    apb_read(dmm_pkg::ADDR_AZMUX, data, err);
    check_data("azmux reset", 32'h98, data);
    read_status_check();
    apb_write(dmm_pkg::ADDR_PRECHARGE, PRECHARGE_TEST, err);
    apb_read(dmm_pkg::ADDR_PRECHARGE, data, err);
    check_data("precharge", 32'(PRECHARGE_TEST), data);
    // hi code b, lo code c
    apb_write(dmm_pkg::ADDR_AZMUX, 32'hBC, err);
    apb_read(dmm_pkg::ADDR_AZMUX, data, err);
    check_data("azmux", 32'hBC, data);
    // az runs only a few cycles here, far short of its first start
    apb_write(dmm_pkg::ADDR_CTRL, 32'd2, err);
    apb_read(dmm_pkg::ADDR_CTRL, data, err);
    check_data("ctrl az", 32'd2, data);
    apb_write(dmm_pkg::ADDR_CTRL, 32'd3, err);
    apb_read(dmm_pkg::ADDR_CTRL, data, err);
    check_data("ctrl code 3", 32'd0, data);
    apb_read(8'h10, data, err);
    check_flag("unmapped pslverr", 1'b1, err);
    apb_write(dmm_pkg::ADDR_STATUS, 32'h55, err);
    check_flag("status write pslverr", 1'b1, err);
    read_status_check();
  endtask

  task automatic test_direct();
    int starts;
    test_name = "direct";
    starts    = start_seen;
    repeat (200)
    begin
      @(negedge clk);
      check_pc("sw_pc", dmm_pkg::SW_PC_BOOT, sw_pc_ctl);
      check_azmux("azmux", 4'hC, azmux);
      check_monitor("monitor", 2'b00, monitor);
    end
    check_count("starts", 16'd0, dmm_pkg::meas_count_t'(start_seen - starts));
    read_status_check();
  endtask

  task automatic test_no_az();
    logic err;
    test_name = "no_az";
    clear_log();
    apb_write(dmm_pkg::ADDR_CTRL, 32'd1, err);
    wait_dones(done_seen + 5);
    exp_status = exp_status + 5;
    // next start is a full precharge away, so the count is still settled
    read_status_check();
    apb_write(dmm_pkg::ADDR_CTRL, 32'd0, err);
    check_count("starts", 16'd5, dmm_pkg::meas_count_t'(start_pc.size()));
    foreach (start_pc[i])
    begin
      check_pc($sformatf("pc at start %0d", i), dmm_pkg::SW_PC_SIGNAL, start_pc[i]);
      check_azmux($sformatf("mux at start %0d", i), 4'hB, start_mux[i]);
      check_monitor($sformatf("monitor at start %0d", i), 2'b10, start_mon[i]);
    end
    check_count("gaps", 16'd4, dmm_pkg::meas_count_t'(gap_q.size()));
    foreach (gap_q[i])
      check_gap($sformatf("gap %0d", i), PRECHARGE_TEST + 2, dmm_pkg::count_t'(gap_q[i]));
  endtask

  task automatic test_az();
    logic err;
    test_name = "az";
    clear_log();
    apb_write(dmm_pkg::ADDR_CTRL, 32'd2, err);
    // three hi and three lo conversions
    wait_dones(done_seen + 6);
    exp_status = exp_status + 6;
    read_status_check();
    apb_write(dmm_pkg::ADDR_CTRL, 32'd0, err);
    check_flag("led0", logic'(exp_status % 2), led0);
    check_count("starts", 16'd6, dmm_pkg::meas_count_t'(start_pc.size()));
    foreach (start_pc[i])
    begin
      // even starts are hi, odd starts are lo
      if (i % 2 == 0)
      begin
        check_pc($sformatf("pc at hi start %0d", i), dmm_pkg::SW_PC_SIGNAL, start_pc[i]);
        check_azmux($sformatf("mux at hi start %0d", i), 4'hB, start_mux[i]);
      end
      else
      begin
        check_pc($sformatf("pc at lo start %0d", i), dmm_pkg::SW_PC_BOOT, start_pc[i]);
        check_azmux($sformatf("mux at lo start %0d", i), 4'hC, start_mux[i]);
      end
      check_monitor($sformatf("monitor at start %0d", i), 2'b10, start_mon[i]);
    end
    check_count("gaps", 16'd5, dmm_pkg::meas_count_t'(gap_q.size()));
    foreach (gap_q[i])
      check_gap($sformatf("gap %0d", i), PRECHARGE_TEST + 2, dmm_pkg::count_t'(gap_q[i]));
  endtask

  task automatic test_switch();
    int   starts;
    logic err;
    test_name = "switch";
    clear_log();
    starts = start_seen;
    apb_write(dmm_pkg::ADDR_CTRL, 32'd1, err);
    // monitor bit 0 marks the precharge pause
    while (monitor[0] !== 1'b1)
      @(negedge clk);
    check_monitor("precharge monitor", 2'b01, monitor);
    apb_write(dmm_pkg::ADDR_CTRL, 32'd0, err);
    repeat (2) @(negedge clk);
    check_pc("parked pc", dmm_pkg::SW_PC_BOOT, sw_pc_ctl);
    check_azmux("parked mux", 4'hC, azmux);
    check_monitor("parked monitor", 2'b00, monitor);
    repeat (100) @(negedge clk);
    check_count("starts", 16'd0, dmm_pkg::meas_count_t'(start_seen - starts));
    read_status_check();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    clk              = 1'b0;
    reset            = 1'b1;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    adc_measure_done = 1'b0;
    errors           = 0;
    checks           = 0;
    cycle            = 0;
    done_seen        = 0;
    start_seen       = 0;
    last_done_cycle  = 0;
    exp_status       = 0;
    done_since_start = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    test_reset_regs();
    test_direct();
    test_no_az();
    test_az();
    test_switch();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
dmm_pkg.sv
modulation_no_az.sv
modulation_az.sv
modulation_apb_regs.sv
modulation_select.sv
modulation_top.sv
tb_modulation.sv
